// File: hw/core_event_ctrl.sv
// stall_i must be synchronous to clk; irq outputs are combinational from the lines
`include "core_region_defs.svh"

module core_event_ctrl (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           stall_i,
  input  logic [`IRQ_COUNT-1:0]          irq_lines_i,
  output logic                           halt_o,
  output logic                           resume_o,
  output logic                           irq_o,
  output logic [$clog2(`IRQ_COUNT)-1:0]  irq_id_o
);

  localparam int unsigned IDW = $clog2(`IRQ_COUNT);

  logic stall_q;
  logic stall_rise;
  logic stall_fall;

  assign stall_rise = stall_i & ~stall_q;
  assign stall_fall = ~stall_i & stall_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stall_q <= 1'b0;
      halt_o <= 1'b0;
      resume_o <= 1'b0;
    end else begin
      stall_q <= stall_i;
      // single-cycle pulses, never held over two edges
      halt_o <= stall_rise & ~halt_o;
      resume_o <= stall_fall & ~resume_o;
    end
  end

  assign irq_o = |irq_lines_i;

  // highest set line wins
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < `IRQ_COUNT; i++) begin
      if (irq_lines_i[i]) begin
        irq_id_o = IDW'(i);
      end
    end
  end

endmodule

// File: hw/core_region.sv
// fetch and LSU requesters must wait for rvalid before the next request; loaders have priority
`include "core_region_defs.svh"

module core_region (
  input  logic                           clk,
  input  logic                           rst_n,

  input  logic                           fetch_req_i,
  input  core_region_pkg::core_req_t     fetch_addr_i,
  output logic                           fetch_gnt_o,
  output core_region_pkg::core_rsp_t     fetch_rsp_o,

  input  logic                           lsu_req_i,
  input  core_region_pkg::core_req_t     lsu_addr_i,
  output logic                           lsu_gnt_o,
  output core_region_pkg::core_rsp_t     lsu_rsp_o,

  output logic                           ext_req_o,
  output core_region_pkg::core_req_t     ext_addr_o,
  input  logic                           ext_gnt_i,
  input  core_region_pkg::core_rsp_t     ext_rsp_i,

  input  core_region_pkg::wide_req_t     instr_load_i,
  output core_region_pkg::ram_word_u     instr_load_rdata_o,
  input  core_region_pkg::wide_req_t     data_load_i,
  output core_region_pkg::ram_word_u     data_load_rdata_o,

  input  logic                           stall_i,
  input  logic [`IRQ_COUNT-1:0]          irq_lines_i,
  output logic                           halt_o,
  output logic                           resume_o,
  output logic                           irq_o,
  output logic [$clog2(`IRQ_COUNT)-1:0]  irq_id_o
);

  import core_region_pkg::*;

  // local data path between demux and data arbiter
  logic data_req;
  core_req_t data_addr;
  logic data_gnt;
  core_rsp_t data_rsp;

  ram_req_t instr_ram_req;
  ram_word_u instr_ram_rdata;
  ram_req_t data_ram_req;
  ram_word_u data_ram_rdata;

  core_event_ctrl u_event_ctrl (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .stall_i     ( stall_i     ),
    .irq_lines_i ( irq_lines_i ),
    .halt_o      ( halt_o      ),
    .resume_o    ( resume_o    ),
    .irq_o       ( irq_o       ),
    .irq_id_o    ( irq_id_o    )
  );

  lsu_demux u_lsu_demux (
    .clk        ( clk        ),
    .rst_n      ( rst_n      ),
    .lsu_req_i  ( lsu_req_i  ),
    .lsu_addr_i ( lsu_addr_i ),
    .lsu_gnt_o  ( lsu_gnt_o  ),
    .lsu_rsp_o  ( lsu_rsp_o  ),
    .ram_req_o  ( data_req   ),
    .ram_addr_o ( data_addr  ),
    .ram_gnt_i  ( data_gnt   ),
    .ram_rsp_i  ( data_rsp   ),
    .ext_req_o  ( ext_req_o  ),
    .ext_addr_o ( ext_addr_o ),
    .ext_gnt_i  ( ext_gnt_i  ),
    .ext_rsp_i  ( ext_rsp_i  )
  );

  // instruction side, read-only for the core
  ram_mux #(
    .BYTES         ( `INSTR_RAM_BYTES ),
    .CORE_WRITABLE ( 1'b0             )
  ) u_instr_mux (
    .clk          ( clk                ),
    .rst_n        ( rst_n              ),
    .wide_req_i   ( instr_load_i       ),
    .wide_rdata_o ( instr_load_rdata_o ),
    .core_req_i   ( fetch_req_i        ),
    .core_addr_i  ( fetch_addr_i       ),
    .core_gnt_o   ( fetch_gnt_o        ),
    .core_rsp_o   ( fetch_rsp_o        ),
    .ram_req_o    ( instr_ram_req      ),
    .ram_rdata_i  ( instr_ram_rdata    )
  );

  sp_ram #(
    .BYTES ( `INSTR_RAM_BYTES )
  ) u_instr_ram (
    .clk       ( clk             ),
    .rst_n     ( rst_n           ),
    .ram_req_i ( instr_ram_req   ),
    .rdata_o   ( instr_ram_rdata )
  );

  ram_mux #(
    .BYTES         ( `DATA_RAM_BYTES ),
    .CORE_WRITABLE ( 1'b1            )
  ) u_data_mux (
    .clk          ( clk               ),
    .rst_n        ( rst_n             ),
    .wide_req_i   ( data_load_i       ),
    .wide_rdata_o ( data_load_rdata_o ),
    .core_req_i   ( data_req          ),
    .core_addr_i  ( data_addr         ),
    .core_gnt_o   ( data_gnt          ),
    .core_rsp_o   ( data_rsp          ),
    .ram_req_o    ( data_ram_req      ),
    .ram_rdata_i  ( data_ram_rdata    )
  );

  sp_ram #(
    .BYTES ( `DATA_RAM_BYTES )
  ) u_data_ram (
    .clk       ( clk            ),
    .rst_n     ( rst_n          ),
    .ram_req_i ( data_ram_req   ),
    .rdata_o   ( data_ram_rdata )
  );

endmodule

// File: hw/core_region_pkg.sv
// word index is sized for the larger RAM, so a smaller RAM ignores the upper index bits
`include "core_region_defs.svh"

package core_region_pkg;

  localparam int unsigned DATA_WORDS = `DATA_RAM_BYTES / (`WIDE_WIDTH / 8);
  localparam int unsigned INSTR_WORDS = `INSTR_RAM_BYTES / (`WIDE_WIDTH / 8);
  localparam int unsigned MAX_WORDS = (DATA_WORDS > INSTR_WORDS) ? DATA_WORDS : INSTR_WORDS;
  localparam int unsigned WORD_IDX_W = $clog2(MAX_WORDS);

  // request from the core side, held until gnt
  typedef struct packed {
    logic [31:0] addr;
    logic we;
    logic [`CORE_WIDTH/8-1:0] be;
    logic [`CORE_WIDTH-1:0] wdata;
  } core_req_t;

  typedef struct packed {
    logic rvalid;
    logic [`CORE_WIDTH-1:0] rdata;
  } core_rsp_t;

  // one RAM word, whole for the loader, split in lanes for the core
  typedef union packed {
    logic [`WIDE_WIDTH-1:0] word;
    logic [`WIDE_WIDTH/`CORE_WIDTH-1:0][`CORE_WIDTH-1:0] lane;
  } ram_word_u;

  typedef struct packed {
    logic req;
    logic [WORD_IDX_W-1:0] idx;
    logic we;
    logic [`WIDE_WIDTH/8-1:0] be;
    ram_word_u wdata;
  } wide_req_t;

  typedef struct packed {
    logic en;
    logic [WORD_IDX_W-1:0] idx;
    logic we;
    logic [`WIDE_WIDTH/8-1:0] be;
    ram_word_u wdata;
  } ram_req_t;

endpackage

// File: hw/lsu_demux.sv
// one outstanding LSU request at a time; the next request waits for the previous rvalid
`include "core_region_defs.svh"

module lsu_demux (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       lsu_req_i,
  input  core_region_pkg::core_req_t lsu_addr_i,
  output logic                       lsu_gnt_o,
  output core_region_pkg::core_rsp_t lsu_rsp_o,
  output logic                       ram_req_o,
  output core_region_pkg::core_req_t ram_addr_o,
  input  logic                       ram_gnt_i,
  input  core_region_pkg::core_rsp_t ram_rsp_i,
  output logic                       ext_req_o,
  output core_region_pkg::core_req_t ext_addr_o,
  input  logic                       ext_gnt_i,
  input  core_region_pkg::core_rsp_t ext_rsp_i
);

  localparam logic OWNER_RAM = 1'b0;
  localparam logic OWNER_EXT = 1'b1;

  logic is_local;
  logic owner_q;
  logic owner_d;

  assign is_local = (lsu_addr_i.addr[31:20] == `LOCAL_PREFIX);

  assign ram_req_o = lsu_req_i & is_local;
  assign ext_req_o = lsu_req_i & ~is_local;

  // both targets see the same request fields
  assign ram_addr_o = lsu_addr_i;
  assign ext_addr_o = lsu_addr_i;

  // remember which side will answer next
  always_comb begin
    owner_d = owner_q;
    lsu_gnt_o = 1'b0;
    if (ext_req_o) begin
      lsu_gnt_o = ext_gnt_i;
      owner_d = OWNER_EXT;
    end else if (ram_req_o) begin
      lsu_gnt_o = ram_gnt_i;
      owner_d = OWNER_RAM;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner_q <= OWNER_RAM;
    end else begin
      owner_q <= owner_d;
    end
  end

  assign lsu_rsp_o.rdata = (owner_q == OWNER_EXT) ? ext_rsp_i.rdata : ram_rsp_i.rdata;
  // only one side can be answering at a time
  assign lsu_rsp_o.rvalid = ext_rsp_i.rvalid | ram_rsp_i.rvalid;

endmodule

// File: hw/ram_mux.sv
// loader always wins and gets no grant; core requests stall while the loader is active
`include "core_region_defs.svh"

module ram_mux #(
  parameter int unsigned BYTES = `DATA_RAM_BYTES,
  parameter bit CORE_WRITABLE = 1'b1
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  core_region_pkg::wide_req_t wide_req_i,
  output core_region_pkg::ram_word_u wide_rdata_o,
  input  logic                       core_req_i,
  input  core_region_pkg::core_req_t core_addr_i,
  output logic                       core_gnt_o,
  output core_region_pkg::core_rsp_t core_rsp_o,
  output core_region_pkg::ram_req_t  ram_req_o,
  input  core_region_pkg::ram_word_u ram_rdata_i
);

  import core_region_pkg::*;

  localparam int unsigned AW = $clog2(BYTES / (`WIDE_WIDTH / 8));
  localparam int unsigned CB = `CORE_WIDTH / 8;
  localparam int unsigned NLANE = `WIDE_WIDTH / `CORE_WIDTH;

  logic core_lane;
  logic lane_q;
  logic core_pend_q;
  logic [WORD_IDX_W-1:0] core_idx;
  logic [`WIDE_WIDTH/8-1:0] core_be;

  assign core_gnt_o = core_req_i & ~wide_req_i.req;

  // bit 2 picks the upper or lower half of the wide word
  assign core_lane = core_addr_i.addr[2];
  assign core_idx = WORD_IDX_W'(core_addr_i.addr[AW+2:3]);

  always_comb begin
    core_be = '0;
    core_be[core_lane*CB +: CB] = core_addr_i.be;

    if (wide_req_i.req) begin
      ram_req_o.en = 1'b1;
      ram_req_o.idx = wide_req_i.idx;
      ram_req_o.we = wide_req_i.we;
      ram_req_o.be = wide_req_i.be;
      ram_req_o.wdata = wide_req_i.wdata;
    end else begin
      ram_req_o.en = core_req_i;
      ram_req_o.idx = core_idx;
      // fetch-only instance never writes
      ram_req_o.we = CORE_WRITABLE & core_addr_i.we;
      ram_req_o.be = CORE_WRITABLE ? core_be : '0;
      ram_req_o.wdata.lane = CORE_WRITABLE ? {NLANE{core_addr_i.wdata}} : '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_pend_q <= 1'b0;
    end else begin
      core_pend_q <= core_gnt_o;
    end
  end

  // lane of the granted access, needed one cycle later
  always_ff @(posedge clk) begin
    if (core_gnt_o) begin
      lane_q <= core_lane;
    end
  end

  assign core_rsp_o.rvalid = core_pend_q;
  assign core_rsp_o.rdata = ram_rdata_i.lane[lane_q];

  // loader data is simply the RAM output one cycle after its request
  assign wide_rdata_o = ram_rdata_i;

endmodule

// File: hw/sp_ram.sv
// BYTES must be a power of two no larger than the package word index covers; write returns old data
`include "core_region_defs.svh"

module sp_ram #(
  parameter int unsigned BYTES = `DATA_RAM_BYTES
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  core_region_pkg::ram_req_t  ram_req_i,
  output core_region_pkg::ram_word_u rdata_o
);

  localparam int unsigned NBE = `WIDE_WIDTH / 8;
  localparam int unsigned DEPTH = BYTES / NBE;
  localparam int unsigned AW = $clog2(DEPTH);

  logic [`WIDE_WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0] idx;

  assign idx = ram_req_i.idx[AW-1:0];

  // byte-wise write of the addressed word
  always_ff @(posedge clk) begin
    if (ram_req_i.en && ram_req_i.we) begin
      for (int b = 0; b < NBE; b++) begin
        if (ram_req_i.be[b]) begin
          mem[idx][b*8 +: 8] <= ram_req_i.wdata.word[b*8 +: 8];
        end
      end
    end
  end

  // registered read on every enabled access
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_o <= '0;
    end else if (ram_req_i.en) begin
      rdata_o.word <= mem[idx];
    end
  end

endmodule

// File: include/core_region_defs.svh
// sizes must be powers of two and the wide word must hold exactly two core words
`ifndef CORE_REGION_DEFS_SVH
`define CORE_REGION_DEFS_SVH

// memory sizes in bytes
`define DATA_RAM_BYTES 32768
`define INSTR_RAM_BYTES 32768

// loader and RAM word width
`define WIDE_WIDTH 64

// core bus word width
`define CORE_WIDTH 32

// upper twelve address bits that select the local data RAM
`define LOCAL_PREFIX 12'h001

// number of interrupt lines
`define IRQ_COUNT 32

`endif

// File: run.sh
#!/usr/bin/env bash
# builds core_region_tb with Verilator, runs it, and looks for the pass line in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f src.f --top-module core_region_tb -o core_region_sim \
  && ./obj_dir/core_region_sim | tee /dev/stderr | grep -q "^Testbench passed$" \
  && echo "run.sh: simulation ok" \
  || { echo "run.sh: simulation did not pass"; exit 1; }

// File: src.f
+incdir+include
hw/core_region_pkg.sv
hw/sp_ram.sv
hw/ram_mux.sv
hw/lsu_demux.sv
hw/core_event_ctrl.sv
hw/core_region.sv
verif/tb_clk_gen.sv
verif/core_region_asserts.sv
verif/core_region_tb.sv

// File: verif/core_region_asserts.sv
// generic port set; inputs of the side that a bind does not use must be tied low
module core_region_asserts (
  input logic clk,
  input logic rst_n,
  input logic loader_req_i,
  input logic core_req_i,
  input logic core_gnt_i,
  input logic core_rvalid_i,
  input logic stall_i,
  input logic halt_i,
  input logic resume_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // loader has priority over the core port
  a_loader_first: assert property (@(posedge clk) disable iff (!rst_n)
    loader_req_i |-> !core_gnt_i) else $error("core granted while the loader requests");

  // a held-off core request stays up until its gnt
  a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    core_req_i && !core_gnt_i |=> core_req_i) else $error("core request dropped before gnt");

  a_rvalid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    core_gnt_i |=> core_rvalid_i) else $error("no rvalid one cycle after gnt");

  a_rvalid_source: assert property (@(posedge clk) disable iff (!rst_n)
    core_rvalid_i |-> $past(core_gnt_i)) else $error("rvalid without a gnt before it");

  // one halt or resume pulse after each stall edge
  a_halt_on_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(stall_i) |=> halt_i) else $error("missing halt pulse");

  a_resume_on_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(stall_i) |=> resume_i) else $error("missing resume pulse");
endmodule

// File: verif/core_region_tb.sv
// models cover a 64-word window of each RAM; inputs change 1 ns after the rising edge
`include "core_region_defs.svh"

module core_region_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import core_region_pkg::*;

  localparam int TIMEOUT_CYCLES = 4000;
  localparam int WINDOW_WORDS = 64;
  localparam int IDW = $clog2(`IRQ_COUNT);
  localparam logic [31:0] LOCAL_BASE = {`LOCAL_PREFIX, 20'h0};
  localparam core_rsp_t NO_RSP = '0;

  logic clk;
  logic rst_n;
  logic fetch_req;
  core_req_t fetch_addr;
  logic fetch_gnt;
  core_rsp_t fetch_rsp;
  logic lsu_req;
  core_req_t lsu_addr;
  logic lsu_gnt;
  core_rsp_t lsu_rsp;
  logic ext_req;
  core_req_t ext_addr;
  logic ext_gnt;
  core_rsp_t ext_rsp;
  wide_req_t instr_load;
  ram_word_u instr_load_rdata;
  wide_req_t data_load;
  ram_word_u data_load_rdata;
  logic stall;
  logic [`IRQ_COUNT-1:0] irq_lines;
  logic halt;
  logic resume;
  logic irq;
  logic [IDW-1:0] irq_id;

  // byte models of both RAMs, word model of the external memory
  logic [7:0] instr_model [`INSTR_RAM_BYTES];
  logic [7:0] data_model [`DATA_RAM_BYTES];
  logic [31:0] ext_model [logic [31:0]];

  int seed;
  int cycle_cnt;
  int rsp_errors;
  int wide_errors;
  int event_errors;
  int port_errors;

  tb_clk_gen u_clk_gen (
    .clk_o   ( clk   ),
    .rst_n_o ( rst_n )
  );

  core_region u_core_region (
    .clk                ( clk              ),
    .rst_n              ( rst_n            ),
    .fetch_req_i        ( fetch_req        ),
    .fetch_addr_i       ( fetch_addr       ),
    .fetch_gnt_o        ( fetch_gnt        ),
    .fetch_rsp_o        ( fetch_rsp        ),
    .lsu_req_i          ( lsu_req          ),
    .lsu_addr_i         ( lsu_addr         ),
    .lsu_gnt_o          ( lsu_gnt          ),
    .lsu_rsp_o          ( lsu_rsp          ),
    .ext_req_o          ( ext_req          ),
    .ext_addr_o         ( ext_addr         ),
    .ext_gnt_i          ( ext_gnt          ),
    .ext_rsp_i          ( ext_rsp          ),
    .instr_load_i       ( instr_load       ),
    .instr_load_rdata_o ( instr_load_rdata ),
    .data_load_i        ( data_load        ),
    .data_load_rdata_o  ( data_load_rdata  ),
    .stall_i            ( stall            ),
    .irq_lines_i        ( irq_lines        ),
    .halt_o             ( halt             ),
    .resume_o           ( resume           ),
    .irq_o              ( irq              ),
    .irq_id_o           ( irq_id           )
  );

  bind ram_mux core_region_asserts u_mux_asserts (
    .clk(clk), .rst_n(rst_n), .loader_req_i(wide_req_i.req), .core_req_i(core_req_i),
    .core_gnt_i(core_gnt_o), .core_rvalid_i(core_rsp_o.rvalid),
    .stall_i(1'b0), .halt_i(1'b0), .resume_i(1'b0)
  );

  bind core_event_ctrl core_region_asserts u_event_asserts (
    .clk(clk), .rst_n(rst_n), .loader_req_i(1'b0), .core_req_i(1'b0),
    .core_gnt_i(1'b0), .core_rvalid_i(1'b0),
    .stall_i(stall_i), .halt_i(halt_o), .resume_i(resume_o)
  );

  function automatic logic [31:0] next_random();
    return $random(seed);
  endfunction

  function automatic int random_index();
    return int'(next_random() % WINDOW_WORDS);
  endfunction

  function automatic ram_word_u random_word();
    ram_word_u w;
    w.word = {next_random(), next_random()};
    return w;
  endfunction

  function automatic ram_word_u model_word(input bit on_data, input int idx);
    ram_word_u w;
    for (int b = 0; b < 8; b++) begin
      w.word[b*8 +: 8] = on_data ? data_model[idx*8 + b] : instr_model[idx*8 + b];
    end
    return w;
  endfunction

  // byte address inside the RAM comes from the low offset bits
  function automatic logic [31:0] model_lane(input bit on_data, input logic [31:0] addr);
    logic [31:0] v;
    int base;
    base = int'(addr[14:2]) * 4;
    for (int k = 0; k < 4; k++) begin
      v[k*8 +: 8] = on_data ? data_model[base + k] : instr_model[base + k];
    end
    return v;
  endfunction

  function automatic logic [31:0] ext_read(input logic [31:0] addr);
    logic [31:0] key;
    key = {addr[31:2], 2'b00};
    if (ext_model.exists(key)) begin
      return ext_model[key];
    end
    // unwritten words follow a pattern of the whole address
    return {key[15:0], key[31:16]} ^ 32'h96e1_3c5a;
  endfunction

  function automatic void ext_write(input core_req_t r);
    logic [31:0] v;
    v = ext_read(r.addr);
    for (int k = 0; k < 4; k++) begin
      if (r.be[k]) v[k*8 +: 8] = r.wdata[k*8 +: 8];
    end
    ext_model[{r.addr[31:2], 2'b00}] = v;
  endfunction

  function automatic void data_write(input core_req_t r);
    int base;
    base = int'(r.addr[14:2]) * 4;
    for (int k = 0; k < 4; k++) begin
      if (r.be[k]) data_model[base + k] = r.wdata[k*8 +: 8];
    end
  endfunction

  function automatic logic [IDW-1:0] highest_irq(input logic [`IRQ_COUNT-1:0] v);
    for (int i = `IRQ_COUNT - 1; i >= 0; i--) begin
      if (v[i]) return IDW'(i);
    end
    return '0;
  endfunction

  function automatic core_req_t random_lsu_req(input bit to_ext);
    core_req_t r;
    logic [31:0] rnd;
    logic [11:0] upper;
    rnd = next_random();
    upper = to_ext ? rnd[31:20] : `LOCAL_PREFIX;
    if (to_ext && upper == `LOCAL_PREFIX) upper = ~upper;
    r.addr = {upper, 20'h0} + 32'(random_index()) * 8 + (rnd[0] ? 32'd4 : 32'd0);
    r.we = rnd[1];
    r.be = r.we ? rnd[5:2] : 4'hf;
    r.wdata = next_random();
    return r;
  endfunction

  task automatic check_core_rsp(input core_rsp_t got, input core_rsp_t exp, input bit with_data,
                                input string what);
    if (got.rvalid !== exp.rvalid || (with_data && got.rdata !== exp.rdata)) begin
      rsp_errors++;
      $display("** Error at %0t: %s response got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_wide(input ram_word_u got, input ram_word_u exp, input string what);
    if (got.word !== exp.word) begin
      wide_errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, what, got.word, exp.word);
    end
  endtask

  task automatic check_event(input logic got_halt, input logic got_resume, input logic got_irq,
                             input logic [IDW-1:0] got_id, input logic exp_halt,
                             input logic exp_resume, input logic exp_irq,
                             input logic [IDW-1:0] exp_id);
    if ({got_halt, got_resume, got_irq, got_id} !== {exp_halt, exp_resume, exp_irq, exp_id}) begin
      event_errors++;
      $display("** Error at %0t: events halt/resume/irq/id got %b/%b/%b/%0d expected %b/%b/%b/%0d",
               $time, got_halt, got_resume, got_irq, got_id,
               exp_halt, exp_resume, exp_irq, exp_id);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      port_errors++;
      $display("** Error at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_req(input core_req_t got, input core_req_t exp, input string what);
    if (got !== exp) begin
      port_errors++;
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic wait_drive_slot();
    @(posedge clk);
    #1;
  endtask

  task automatic load_write(input bit on_data, input int idx, input logic [7:0] be,
                            input ram_word_u d);
    wide_req_t r;
    r.req = 1'b1;
    r.idx = WORD_IDX_W'(idx);
    r.we = 1'b1;
    r.be = be;
    r.wdata = d;
    wait_drive_slot();
    if (on_data) data_load = r;
    else instr_load = r;
    for (int b = 0; b < 8; b++) begin
      if (be[b] && on_data) data_model[idx*8 + b] = d.word[b*8 +: 8];
      if (be[b] && !on_data) instr_model[idx*8 + b] = d.word[b*8 +: 8];
    end
    wait_drive_slot();
    data_load = '0;
    instr_load = '0;
  endtask

  task automatic load_read(input bit on_data, input int idx);
    wide_req_t r;
    r = '0;
    r.req = 1'b1;
    r.idx = WORD_IDX_W'(idx);
    wait_drive_slot();
    if (on_data) data_load = r;
    else instr_load = r;
    wait_drive_slot();
    data_load = '0;
    instr_load = '0;
    @(negedge clk);
    check_wide(on_data ? data_load_rdata : instr_load_rdata, model_word(on_data, idx),
               "loader read");
  endtask

  task automatic fetch_word(input logic [31:0] addr);
    core_req_t r;
    core_rsp_t exp;
    r = '0;
    r.addr = addr;
    r.be = 4'hf;
    exp.rvalid = 1'b1;
    exp.rdata = model_lane(1'b0, addr);
    wait_drive_slot();
    fetch_req = 1'b1;
    fetch_addr = r;
    @(negedge clk);
    while (!fetch_gnt) begin
      check_core_rsp(fetch_rsp, NO_RSP, 1'b0, "fetch before gnt");
      wait_drive_slot();
      @(negedge clk);
    end
    // rvalid must wait for the cycle after gnt
    check_core_rsp(fetch_rsp, NO_RSP, 1'b0, "fetch at gnt");
    wait_drive_slot();
    fetch_req = 1'b0;
    @(negedge clk);
    check_core_rsp(fetch_rsp, exp, 1'b1, "fetch");
  endtask

  // one LSU access; the external side is answered here with random gnt and rvalid delays
  task automatic lsu_access(input core_req_t r);
    bit ext;
    int gnt_wait;
    int rsp_wait;
    int n;
    logic [31:0] rnd;
    core_rsp_t exp;
    ext = (r.addr[31:20] != `LOCAL_PREFIX);
    rnd = next_random();
    gnt_wait = ext ? int'(rnd[1:0]) : 0;
    rsp_wait = int'(rnd[3:2]) % 3 + 1;
    exp.rvalid = 1'b1;
    exp.rdata = ext ? ext_read(r.addr) : model_lane(1'b1, r.addr);
    n = 0;
    wait_drive_slot();
    lsu_req = 1'b1;
    lsu_addr = r;
    ext_gnt = ext && (gnt_wait == 0);
    @(negedge clk);
    while (!lsu_gnt) begin
      check_flag(ext_req, ext, "ext_req while waiting");
      check_core_rsp(lsu_rsp, NO_RSP, 1'b0, "lsu before gnt");
      wait_drive_slot();
      n++;
      ext_gnt = ext && (n >= gnt_wait);
      @(negedge clk);
    end
    check_flag(ext_req, ext, "ext_req at gnt");
    check_core_rsp(lsu_rsp, NO_RSP, 1'b0, "lsu at gnt");
    if (ext) check_req(ext_addr, r, "external request");
    if (r.we && ext) ext_write(r);
    if (r.we && !ext) data_write(r);
    wait_drive_slot();
    lsu_req = 1'b0;
    ext_gnt = 1'b0;
    if (ext) begin
      for (int c = 1; c < rsp_wait; c++) begin
        @(negedge clk);
        check_core_rsp(lsu_rsp, NO_RSP, 1'b0, "lsu before external rvalid");
        wait_drive_slot();
      end
      ext_rsp.rvalid = 1'b1;
      ext_rsp.rdata = exp.rdata;
    end
    @(negedge clk);
    check_core_rsp(lsu_rsp, exp, !r.we, ext ? "lsu external" : "lsu local");
    if (ext) begin
      wait_drive_slot();
      ext_rsp = '0;
    end
  endtask

  // loader and core hit the same RAM in one cycle
  task automatic conflict_access(input bit on_data, input int idx, input bit lane);
    wide_req_t lr;
    core_req_t r;
    core_rsp_t exp;
    lr = '0;
    lr.req = 1'b1;
    lr.idx = WORD_IDX_W'(idx);
    r = '0;
    r.addr = (on_data ? LOCAL_BASE : 32'h0) + 32'(idx) * 8 + (lane ? 32'd4 : 32'd0);
    r.be = 4'hf;
    exp.rvalid = 1'b1;
    exp.rdata = model_lane(on_data, r.addr);
    wait_drive_slot();
    if (on_data) begin
      data_load = lr;
      lsu_req = 1'b1;
      lsu_addr = r;
    end else begin
      instr_load = lr;
      fetch_req = 1'b1;
      fetch_addr = r;
    end
    @(negedge clk);
    check_flag(on_data ? lsu_gnt : fetch_gnt, 1'b0, "core gnt while loader requests");
    wait_drive_slot();
    data_load = '0;
    instr_load = '0;
    @(negedge clk);
    check_wide(on_data ? data_load_rdata : instr_load_rdata, model_word(on_data, idx),
               "loader read in conflict");
    check_flag(on_data ? lsu_gnt : fetch_gnt, 1'b1, "core gnt after loader");
    wait_drive_slot();
    lsu_req = 1'b0;
    fetch_req = 1'b0;
    @(negedge clk);
    check_core_rsp(on_data ? lsu_rsp : fetch_rsp, exp, 1'b1, "core read after conflict");
  endtask

  task automatic run_event_checks(input int n);
    logic prev;
    logic cur;
    logic exp_halt;
    logic exp_resume;
    logic [31:0] rnd;
    logic [31:0] sh;
    prev = 1'b0;
    cur = 1'b0;
    repeat (n) begin
      wait_drive_slot();
      // the edge just passed saw cur against the previous level
      exp_halt = cur & ~prev;
      exp_resume = ~cur & prev;
      prev = cur;
      rnd = next_random();
      sh = next_random();
      cur = rnd[0];
      stall = cur;
      irq_lines = sh[3] ? `IRQ_COUNT'(rnd >> sh[8:4]) : '0;
      @(negedge clk);
      check_event(halt, resume, irq, irq_id, exp_halt, exp_resume, |irq_lines,
                  highest_irq(irq_lines));
    end
  endtask

  task automatic report_counts();
    $display("errors: response %0d, loader %0d, event %0d, port %0d",
             rsp_errors, wide_errors, event_errors, port_errors);
  endtask

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    report_counts();
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  initial begin : main
    logic [31:0] rnd;
    seed = 32'h2da3_caa4;
    rsp_errors = 0;
    wide_errors = 0;
    event_errors = 0;
    port_errors = 0;
    fetch_req = 1'b0;
    fetch_addr = '0;
    lsu_req = 1'b0;
    lsu_addr = '0;
    ext_gnt = 1'b0;
    ext_rsp = '0;
    instr_load = '0;
    data_load = '0;
    stall = 1'b0;
    irq_lines = '0;
    @(posedge rst_n);
    repeat (2) @(posedge clk);
    @(negedge clk);
    // idle outputs after reset
    check_flag(fetch_gnt | lsu_gnt | ext_req, 1'b0, "gnt or ext_req after reset");
    check_core_rsp(fetch_rsp, NO_RSP, 1'b0, "fetch after reset");
    check_core_rsp(lsu_rsp, NO_RSP, 1'b0, "lsu after reset");
    check_event(halt, resume, irq, irq_id, 1'b0, 1'b0, 1'b0, '0);

    for (int i = 0; i < WINDOW_WORDS; i++) begin
      load_write(1'b0, i, 8'hff, random_word());
      load_write(1'b1, i, 8'hff, random_word());
    end
    repeat (30) begin
      rnd = next_random();
      load_write(rnd[8], random_index(), rnd[7:0], random_word());
    end
    repeat (30) begin
      rnd = next_random();
      load_read(rnd[0], random_index());
    end
    repeat (60) begin
      rnd = next_random();
      fetch_word(32'(random_index()) * 8 + (rnd[0] ? 32'd4 : 32'd0));
    end
    repeat (80) lsu_access(random_lsu_req(1'b0));
    repeat (80) begin
      rnd = next_random();
      lsu_access(random_lsu_req(rnd[0]));
    end
    // local writes visible to the loader, external ones left no trace
    for (int i = 0; i < WINDOW_WORDS; i++) load_read(1'b1, i);
    repeat (20) begin
      rnd = next_random();
      conflict_access(rnd[0], random_index(), rnd[1]);
    end
    run_event_checks(120);

    report_counts();
    if (rsp_errors + wide_errors + event_errors + port_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end
endmodule

// File: verif/tb_clk_gen.sv
// free-running 8 ns clock; reset is released 1 ns after the tenth rising edge
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end
endmodule
